// ==== chiplet_endpoint.f ====
src/endpoint_pkg.sv
src/word_bus_if.sv
src/word_cache.sv
src/packet_sender.sv
src/packet_receiver.sv
src/chiplet_endpoint.sv
testbench/endpoint_tb.sv

// ==== testbench/endpoint_tb.sv ====
`default_nettype none

module endpoint_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {OP_WRITE, OP_READ, OP_SEND, OP_INJECT, OP_WAIT_IDLE} op_t;

    localparam int MAX_ROWS = 128;
    localparam int CYCLES_PER_ROW = 200;
    localparam int QUIET_CYCLES = 4;
    localparam logic [7:0] TB_NODE_ID = 8'h5A;

    logic clk = 1'b0;
    logic n_rst;
    logic bus_wen;
    logic bus_ren;
    logic [15:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [3:0] bus_strobe;
    logic [31:0] bus_rdata;
    logic bus_error;
    logic bus_stall;
    logic tx_valid;
    logic [31:0] tx_flit;
    logic tx_credit_return;
    logic rx_valid;
    logic [31:0] rx_flit;
    logic rx_credit_return;

    // Loopback and injection.
    logic loopback = 1'b0;
    logic inj_valid = 1'b0;
    logic [31:0] inj_flit = '0;
    logic [6:0] credit_line = '0;
    int credit_delay = 0;

    // Stimulus table.
    op_t row_op [MAX_ROWS];
    logic [15:0] row_addr [MAX_ROWS];
    logic [31:0] row_data [MAX_ROWS];
    logic [31:0] row_exp [MAX_ROWS];
    logic row_chk [MAX_ROWS];
    logic row_err [MAX_ROWS];
    int row_delay [MAX_ROWS];
    int num_rows = 0;

    // Reference model.
    logic [31:0] model_tx [128];
    logic [31:0] exp_rx [128];
    logic [31:0] inj_buf [16];
    int start_word [4];
    int slot_len [4];
    int rx_wr = 0;
    int good_pkts = 0;
    int bad_pkts = 0;
    int flits_due = 0;
    int seed = 57461;

    int cycles = 0;
    int cycle_limit = 0;
    int in_flight = 0;
    int flits_seen = 0;
    logic rx_valid_d = 1'b0;

    chiplet_endpoint #(
        .NODE_ID(TB_NODE_ID)
    ) chiplet_endpoint_inst (
        .clk(clk),
        .n_rst(n_rst),
        .bus_wen(bus_wen),
        .bus_ren(bus_ren),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_strobe(bus_strobe),
        .bus_rdata(bus_rdata),
        .bus_error(bus_error),
        .bus_stall(bus_stall),
        .tx_valid(tx_valid),
        .tx_flit(tx_flit),
        .tx_credit_return(tx_credit_return),
        .rx_valid(rx_valid),
        .rx_flit(rx_flit),
        .rx_credit_return(rx_credit_return)
    );

    always #5 clk = ~clk;

    assign rx_valid = loopback ? tx_valid : inj_valid;
    assign rx_flit = loopback ? tx_flit : inj_flit;
    assign tx_credit_return = credit_line[credit_delay];

    // Tap 0 lines up with the direct credit path.
    always @(negedge clk) begin
        credit_line <= {credit_line[5:0], loopback & rx_credit_return};
    end

    // ##############################
    // Monitors
    // ##############################

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure("Timeout, the run went past its cycle limit.");
        end
        if (tx_valid) begin
            in_flight++;
            flits_seen++;
        end
        if (tx_credit_return) begin
            in_flight--;
        end
        if (in_flight > endpoint_pkg::LINK_CREDITS) begin
            stop_with_failure("More flits in flight than the link has credits.");
        end
        // Credit goes back one cycle after each accepted flit.
        if (n_rst) begin
            check_value("rx_credit_return", rx_valid_d, rx_credit_return);
        end
        rx_valid_d = rx_valid;
    end

    task automatic stop_with_failure(input string reason);
        if (reason.len() > 0) begin
            $display("%s", reason);
        end
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure("");
        end
    endtask

    function automatic logic [31:0] header_from_node(input logic [31:0] h);
        header_from_node = {h[31:24], TB_NODE_ID, h[15:0]};
    endfunction

    // ##############################
    // Table construction
    // ##############################

    task automatic add_row(input op_t op, input logic [15:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input logic chk, input logic err,
                           input int delay);
        row_op[num_rows] = op;
        row_addr[num_rows] = addr;
        row_data[num_rows] = data;
        row_exp[num_rows] = exp;
        row_chk[num_rows] = chk;
        row_err[num_rows] = err;
        row_delay[num_rows] = delay;
        num_rows++;
    endtask

    // Expected rx words follow in the order the sender picks slots.
    task automatic queue_send(input int slot, input int delay);
        int base;
        base = start_word[slot];
        add_row(OP_SEND, endpoint_pkg::TX_SEND_ADDR, slot, '0, 1'b0, 1'b0, delay);
        exp_rx[rx_wr % 128] = header_from_node(model_tx[base]);
        for (int k = 1; k <= slot_len[slot]; k++) begin
            exp_rx[(rx_wr + k) % 128] = model_tx[base + k];
        end
        rx_wr += slot_len[slot] + 1;
        flits_due += slot_len[slot] + 2;
        good_pkts++;
    endtask

    task automatic queue_wait();
        add_row(OP_WAIT_IDLE, endpoint_pkg::RX_STATUS_ADDR, flits_due,
                {good_pkts[15:0], bad_pkts[15:0]}, 1'b1, 1'b0, 0);
        flits_due = 0;
    endtask

    task automatic queue_rx_reads(input int first, input int count);
        for (int k = 0; k < count; k++) begin
            add_row(OP_READ, endpoint_pkg::RX_CACHE_BASE + 4 * ((first + k) % 128), '0,
                    exp_rx[(first + k) % 128], 1'b1, 1'b0, 0);
        end
    endtask

    task automatic build_table();
        logic [31:0] word;
        int first;
        slot_len[0] = 3;
        slot_len[1] = 5;
        slot_len[2] = 2;
        slot_len[3] = 1;
        for (int s = 0; s < endpoint_pkg::NUM_MSGS; s++) begin
            start_word[s] = 16 * s;
            add_row(OP_WRITE, endpoint_pkg::PKT_START_BASE + 4 * s, (64 * s) | 3, '0,
                    1'b0, 1'b0, 0);
        end
        for (int s = 0; s < endpoint_pkg::NUM_MSGS; s++) begin
            add_row(OP_READ, endpoint_pkg::PKT_START_BASE + 4 * s, '0, 64 * s, 1'b1, 1'b0, 0);
        end
        add_row(OP_READ, 16'h4000, '0, endpoint_pkg::BAD_READ_DATA, 1'b1, 1'b1, 0);
        add_row(OP_WRITE, endpoint_pkg::RX_STATUS_ADDR, 32'h1234, endpoint_pkg::BAD_READ_DATA,
                1'b1, 1'b1, 0);
        add_row(OP_READ, endpoint_pkg::RX_STATUS_ADDR, '0, '0, 1'b1, 1'b0, 0);

        // Slots 0 to 2 hold packets, source field set to a dummy id.
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k <= slot_len[s]; k++) begin
                if (k == 0) begin
                    word = ((32'h10 + s) << 24) | 32'h0077_0000 | slot_len[s];
                end else begin
                    word = $random(seed);
                end
                model_tx[start_word[s] + k] = word;
                add_row(OP_WRITE, endpoint_pkg::TX_CACHE_BASE + 4 * (start_word[s] + k), word,
                        '0, 1'b0, 1'b0, 0);
            end
        end
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k <= slot_len[s]; k++) begin
                add_row(OP_READ, endpoint_pkg::TX_CACHE_BASE + 4 * (start_word[s] + k), '0,
                        model_tx[start_word[s] + k], 1'b1, 1'b0, 0);
            end
        end
        add_row(OP_WRITE, endpoint_pkg::RX_CACHE_BASE + 8, 32'hFACE,
                endpoint_pkg::BAD_READ_DATA, 1'b1, 1'b1, 0);

        first = rx_wr;
        queue_send(0, 0);
        queue_wait();
        queue_rx_reads(first, rx_wr - first);
        first = rx_wr;
        queue_send(1, 6);
        queue_wait();
        queue_rx_reads(first, rx_wr - first);

        add_row(OP_SEND, endpoint_pkg::TX_SEND_ADDR, endpoint_pkg::NUM_MSGS, '0,
                1'b0, 1'b1, 2);
        queue_wait();

        // Injected packet with a flipped checksum bit.
        inj_buf[0] = {TB_NODE_ID, 8'h33, 8'h00, 8'h02};
        inj_buf[1] = $random(seed);
        inj_buf[2] = $random(seed);
        inj_buf[3] = inj_buf[0] ^ inj_buf[1] ^ inj_buf[2] ^ 32'h1;
        add_row(OP_INJECT, 16'd4, '0, '0, 1'b0, 1'b0, 0);
        first = rx_wr;
        for (int k = 0; k < 3; k++) begin
            exp_rx[(rx_wr + k) % 128] = inj_buf[k];
        end
        rx_wr += 3;
        bad_pkts++;
        queue_wait();
        queue_rx_reads(first, 3);

        // Slot 1 keeps the sender busy, so slot 0 overtakes slot 2.
        first = rx_wr;
        queue_send(1, 3);
        add_row(OP_SEND, endpoint_pkg::TX_SEND_ADDR, 2, '0, 1'b0, 1'b0, 3);
        queue_send(0, 3);
        num_rows--;
        add_row(OP_SEND, endpoint_pkg::TX_SEND_ADDR, 0, '0, 1'b0, 1'b0, 3);
        queue_send(2, 3);
        num_rows--;
        queue_wait();
        queue_rx_reads(first, rx_wr - first);
    endtask

    // ##############################
    // Row execution
    // ##############################

    // Starts and ends on a falling edge.
    task automatic host_access(input logic wen, input logic ren, input logic [15:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata,
                               output logic err);
        bus_wen = wen;
        bus_ren = ren;
        bus_addr = addr;
        bus_wdata = data;
        bus_strobe = 4'hF;
        @(posedge clk);
        while (bus_stall) begin
            @(posedge clk);
        end
        rdata = bus_rdata;
        err = bus_error;
        @(negedge clk);
        bus_wen = 1'b0;
        bus_ren = 1'b0;
    endtask

    task automatic apply_row(input int i);
        logic [31:0] rdata;
        logic err;
        int quiet;
        case (row_op[i])
            OP_WRITE, OP_READ: begin
                host_access(row_op[i] == OP_WRITE, row_op[i] == OP_READ, row_addr[i],
                            row_data[i], rdata, err);
                if (row_chk[i]) begin
                    check_value("bus_rdata", row_exp[i], rdata);
                end
                check_value("bus_error", row_err[i], err);
            end
            OP_SEND: begin
                loopback = 1'b1;
                credit_delay = row_delay[i];
                host_access(1'b1, 1'b0, row_addr[i], row_data[i], rdata, err);
                check_value("bus_error", row_err[i], err);
            end
            OP_INJECT: begin
                loopback = 1'b0;
                for (int k = 0; k < row_addr[i]; k++) begin
                    inj_valid = 1'b1;
                    inj_flit = inj_buf[row_data[i] + k];
                    @(negedge clk);
                end
                inj_valid = 1'b0;
                inj_flit = '0;
            end
            default: begin
                quiet = 0;
                while (quiet < QUIET_CYCLES) begin
                    @(negedge clk);
                    if (!tx_valid && !rx_valid && in_flight == 0) begin
                        quiet++;
                    end else begin
                        quiet = 0;
                    end
                end
                check_value("tx flit count", row_data[i], flits_seen);
                flits_seen = 0;
                host_access(1'b0, 1'b1, row_addr[i], '0, rdata, err);
                check_value("rx status", row_exp[i], rdata);
                check_value("bus_error", row_err[i], err);
            end
        endcase
    endtask

    initial begin
        n_rst = 1'b0;
        bus_wen = 1'b0;
        bus_ren = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        bus_strobe = '0;
        build_table();
        cycle_limit = num_rows * CYCLES_PER_ROW;
        repeat (10) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/chiplet_endpoint.sv ====
`default_nettype none

module chiplet_endpoint #(
    parameter endpoint_pkg::node_id_t NODE_ID = 8'h01
) (
    input wire logic clk,
    input wire logic n_rst,
    input wire logic bus_wen,
    input wire logic bus_ren,
    input wire endpoint_pkg::host_addr_t bus_addr,
    input wire endpoint_pkg::word_t bus_wdata,
    input wire logic [3:0] bus_strobe,
    output endpoint_pkg::word_t bus_rdata,
    output logic bus_error,
    output logic bus_stall,
    output logic tx_valid,
    output endpoint_pkg::word_t tx_flit,
    input wire logic tx_credit_return,
    input wire logic rx_valid,
    input wire endpoint_pkg::word_t rx_flit,
    output logic rx_credit_return
);

    word_bus_if tx_cache_bus ();
    word_bus_if sender_bus ();
    word_bus_if rx_cache_bus ();
    word_bus_if rx_write_bus ();

    endpoint_pkg::cache_addr_t start_addr [endpoint_pkg::NUM_MSGS];
    logic [endpoint_pkg::NUM_MSGS-1:0] trigger;
    endpoint_pkg::pkt_count_t good_count;
    endpoint_pkg::pkt_count_t error_count;
    endpoint_pkg::msg_idx_t reg_idx;
    endpoint_pkg::cache_addr_t host_word;
    logic host_req;
    logic in_start;
    logic in_tx;
    logic in_rx;
    logic sender_req;
    logic rx_owner;

    // ##############################
    // Address decode
    // ##############################

    assign host_req = bus_wen | bus_ren;
    assign reg_idx = bus_addr[3:2];
    assign host_word = bus_addr[8:2];

    assign in_start = endpoint_pkg::host_addr_t'(bus_addr - endpoint_pkg::PKT_START_BASE)
                      < endpoint_pkg::host_addr_t'(endpoint_pkg::NUM_MSGS * 4);
    assign in_tx = endpoint_pkg::host_addr_t'(bus_addr - endpoint_pkg::TX_CACHE_BASE)
                   < endpoint_pkg::host_addr_t'(endpoint_pkg::CACHE_WORDS * 4);
    assign in_rx = endpoint_pkg::host_addr_t'(bus_addr - endpoint_pkg::RX_CACHE_BASE)
                   < endpoint_pkg::host_addr_t'(endpoint_pkg::CACHE_WORDS * 4);

    // Start addresses kept as word indices.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < endpoint_pkg::NUM_MSGS; i++) begin
                start_addr[i] <= '0;
            end
        end else if (bus_wen && in_start) begin
            start_addr[reg_idx] <= bus_wdata[8:2];
        end
    end

    // ##############################
    // Cache arbitration
    // ##############################

    assign sender_req = sender_bus.ren | sender_bus.wen;
    assign rx_owner = rx_write_bus.wen | rx_write_bus.ren;

    // Sender first, host only when it is quiet.
    always_comb begin
        if (sender_req) begin
            tx_cache_bus.wen = sender_bus.wen;
            tx_cache_bus.ren = sender_bus.ren;
            tx_cache_bus.addr = sender_bus.addr;
            tx_cache_bus.wdata = sender_bus.wdata;
            tx_cache_bus.strobe = sender_bus.strobe;
        end else begin
            tx_cache_bus.wen = bus_wen && in_tx;
            tx_cache_bus.ren = bus_ren && in_tx;
            tx_cache_bus.addr = host_word;
            tx_cache_bus.wdata = bus_wdata;
            tx_cache_bus.strobe = bus_strobe;
        end
    end
    assign sender_bus.rdata = tx_cache_bus.rdata;

    // Host may only read the rx cache.
    assign rx_cache_bus.wen = rx_write_bus.wen;
    assign rx_cache_bus.ren = rx_owner ? rx_write_bus.ren : (bus_ren && in_rx);
    assign rx_cache_bus.addr = rx_owner ? rx_write_bus.addr : host_word;
    assign rx_cache_bus.wdata = rx_write_bus.wdata;
    assign rx_cache_bus.strobe = rx_write_bus.strobe;
    assign rx_write_bus.rdata = rx_cache_bus.rdata;

    // ##############################
    // Host response
    // ##############################

    always_comb begin
        bus_rdata = endpoint_pkg::BAD_READ_DATA;
        bus_error = 1'b0;
        bus_stall = 1'b0;
        trigger = '0;
        if (host_req) begin
            if (in_start) begin
                if (bus_ren) begin
                    bus_rdata = endpoint_pkg::word_t'({start_addr[reg_idx], 2'b00});
                end
            end else if (bus_addr == endpoint_pkg::TX_SEND_ADDR) begin
                if (bus_wen) begin
                    if (bus_wdata < endpoint_pkg::word_t'(endpoint_pkg::NUM_MSGS)) begin
                        trigger[endpoint_pkg::msg_idx_t'(bus_wdata)] = 1'b1;
                    end else begin
                        bus_error = 1'b1;
                    end
                end
            end else if (bus_addr == endpoint_pkg::RX_STATUS_ADDR) begin
                if (bus_wen) begin
                    bus_error = 1'b1;
                end else begin
                    bus_rdata = {good_count, error_count};
                end
            end else if (in_tx) begin
                if (sender_req) begin
                    bus_stall = 1'b1;
                end else if (bus_ren) begin
                    bus_rdata = tx_cache_bus.rdata;
                end
            end else if (in_rx) begin
                if (bus_wen) begin
                    bus_error = 1'b1;
                end else if (rx_owner) begin
                    bus_stall = 1'b1;
                end else begin
                    bus_rdata = rx_cache_bus.rdata;
                end
            end else begin
                bus_error = 1'b1;
            end
        end
    end

    // ##############################
    // Instances
    // ##############################

    word_cache tx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .bus(tx_cache_bus)
    );

    word_cache rx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .bus(rx_cache_bus)
    );

    packet_sender #(
        .NODE_ID(NODE_ID)
    ) sender (
        .clk(clk),
        .n_rst(n_rst),
        .trigger(trigger),
        .start_addr(start_addr),
        .cache(sender_bus),
        .tx_valid(tx_valid),
        .tx_flit(tx_flit),
        .tx_credit_return(tx_credit_return)
    );

    packet_receiver receiver (
        .clk(clk),
        .n_rst(n_rst),
        .rx_valid(rx_valid),
        .rx_flit(rx_flit),
        .cache(rx_write_bus),
        .rx_credit_return(rx_credit_return),
        .good_count(good_count),
        .error_count(error_count)
    );

endmodule

`default_nettype wire

// ==== src/packet_receiver.sv ====
`default_nettype none

module packet_receiver (
    input wire logic clk,
    input wire logic n_rst,
    input wire logic rx_valid,
    input wire endpoint_pkg::word_t rx_flit,
    word_bus_if.requester cache,
    output logic rx_credit_return,
    output endpoint_pkg::pkt_count_t good_count,
    output endpoint_pkg::pkt_count_t error_count
);

    endpoint_pkg::receiver_state_t state;
    endpoint_pkg::cache_addr_t wr_ptr;
    endpoint_pkg::pkt_len_t remaining;
    endpoint_pkg::pkt_len_t hdr_len;
    endpoint_pkg::word_t running_xor;

    assign hdr_len = rx_flit[endpoint_pkg::HDR_LEN_LSB +: 8];

    // Header and payload go straight to the cache.
    assign cache.wen = rx_valid && (state != endpoint_pkg::RCV_CHECKSUM);
    assign cache.ren = 1'b0;
    assign cache.addr = wr_ptr;
    assign cache.wdata = rx_flit;
    assign cache.strobe = 4'hF;

    // One credit back per accepted flit.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rx_credit_return <= 1'b0;
        end else begin
            rx_credit_return <= rx_valid;
        end
    end

    // ##############################
    // Receive FSM
    // ##############################

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= endpoint_pkg::RCV_HEADER;
            wr_ptr <= '0;
            remaining <= '0;
            running_xor <= '0;
            good_count <= '0;
            error_count <= '0;
        end else if (rx_valid) begin
            case (state)
                endpoint_pkg::RCV_HEADER: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    running_xor <= rx_flit;
                    remaining <= hdr_len;
                    if (hdr_len == '0) begin
                        state <= endpoint_pkg::RCV_CHECKSUM;
                    end else begin
                        state <= endpoint_pkg::RCV_PAYLOAD;
                    end
                end
                endpoint_pkg::RCV_PAYLOAD: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    running_xor <= running_xor ^ rx_flit;
                    remaining <= remaining - 1'b1;
                    if (remaining == 8'd1) begin
                        state <= endpoint_pkg::RCV_CHECKSUM;
                    end
                end
                default: begin
                    // Pointer keeps going, bad packet stays in place.
                    if (rx_flit == running_xor) begin
                        good_count <= good_count + 1'b1;
                    end else begin
                        error_count <= error_count + 1'b1;
                    end
                    state <= endpoint_pkg::RCV_HEADER;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/packet_sender.sv ====
`default_nettype none

module packet_sender #(
    parameter endpoint_pkg::node_id_t NODE_ID = 8'h01
) (
    input wire logic clk,
    input wire logic n_rst,
    input wire logic [endpoint_pkg::NUM_MSGS-1:0] trigger,
    input wire endpoint_pkg::cache_addr_t start_addr [endpoint_pkg::NUM_MSGS],
    word_bus_if.requester cache,
    output logic tx_valid,
    output endpoint_pkg::word_t tx_flit,
    input wire logic tx_credit_return
);

    endpoint_pkg::sender_state_t state;
    logic [endpoint_pkg::NUM_MSGS-1:0] pending;
    logic [endpoint_pkg::NUM_MSGS-1:0] clear_mask;
    endpoint_pkg::msg_idx_t sel_slot;
    endpoint_pkg::cache_addr_t rd_ptr;
    endpoint_pkg::pkt_len_t remaining;
    endpoint_pkg::word_t checksum;
    endpoint_pkg::word_t hdr_flit;
    endpoint_pkg::credit_t credits;
    logic start_send;

    // ##############################
    // Pending-send table
    // ##############################

    // Lowest pending slot wins.
    always_comb begin
        sel_slot = '0;
        for (int i = endpoint_pkg::NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_slot = endpoint_pkg::msg_idx_t'(i);
            end
        end
    end

    assign start_send = (state == endpoint_pkg::SND_IDLE) && (|pending);

    always_comb begin
        clear_mask = '0;
        if (start_send) begin
            clear_mask[sel_slot] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | trigger;
        end
    end

    // ##############################
    // Link side
    // ##############################

    assign tx_valid = (state != endpoint_pkg::SND_IDLE) && (credits != '0);

    assign cache.ren = tx_valid && (state != endpoint_pkg::SND_CHECKSUM);
    assign cache.wen = 1'b0;
    assign cache.addr = rd_ptr;
    assign cache.wdata = '0;
    assign cache.strobe = '0;

    // Source field is rewritten with our own id.
    always_comb begin
        hdr_flit = cache.rdata;
        hdr_flit[endpoint_pkg::HDR_SRC_LSB +: $bits(endpoint_pkg::node_id_t)] = NODE_ID;
    end

    always_comb begin
        case (state)
            endpoint_pkg::SND_HEADER: tx_flit = hdr_flit;
            endpoint_pkg::SND_PAYLOAD: tx_flit = cache.rdata;
            endpoint_pkg::SND_CHECKSUM: tx_flit = checksum;
            default: tx_flit = '0;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            credits <= endpoint_pkg::credit_t'(endpoint_pkg::LINK_CREDITS);
        end else if (tx_credit_return && !tx_valid) begin
            if (credits < endpoint_pkg::credit_t'(endpoint_pkg::LINK_CREDITS)) begin
                credits <= credits + 1'b1;
            end
        end else if (tx_valid && !tx_credit_return) begin
            credits <= credits - 1'b1;
        end
    end

    // ##############################
    // Transmit FSM
    // ##############################

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= endpoint_pkg::SND_IDLE;
            rd_ptr <= '0;
            remaining <= '0;
            checksum <= '0;
        end else begin
            case (state)
                endpoint_pkg::SND_IDLE: begin
                    if (start_send) begin
                        rd_ptr <= start_addr[sel_slot];
                        state <= endpoint_pkg::SND_HEADER;
                    end
                end
                endpoint_pkg::SND_HEADER: begin
                    if (tx_valid) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        checksum <= hdr_flit;
                        remaining <= hdr_flit[endpoint_pkg::HDR_LEN_LSB +: 8];
                        if (hdr_flit[endpoint_pkg::HDR_LEN_LSB +: 8] == '0) begin
                            state <= endpoint_pkg::SND_CHECKSUM;
                        end else begin
                            state <= endpoint_pkg::SND_PAYLOAD;
                        end
                    end
                end
                endpoint_pkg::SND_PAYLOAD: begin
                    if (tx_valid) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        checksum <= checksum ^ cache.rdata;
                        remaining <= remaining - 1'b1;
                        if (remaining == 8'd1) begin
                            state <= endpoint_pkg::SND_CHECKSUM;
                        end
                    end
                end
                default: begin
                    if (tx_valid) begin
                        state <= endpoint_pkg::SND_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/word_cache.sv ====
`default_nettype none

module word_cache (
    input wire logic clk,
    input wire logic n_rst,
    word_bus_if.cache bus
);

    endpoint_pkg::word_t mem [endpoint_pkg::CACHE_WORDS];

    // Byte-strobed write.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < endpoint_pkg::CACHE_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.strobe[b]) begin
                    mem[bus.addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Idle read port returns the marker word.
    always_comb begin
        if (bus.ren) begin
            bus.rdata = mem[bus.addr];
        end else begin
            bus.rdata = endpoint_pkg::BAD_READ_DATA;
        end
    end

endmodule

`default_nettype wire

// ==== src/word_bus_if.sv ====
`default_nettype none

interface word_bus_if;

    logic wen;
    logic ren;
    endpoint_pkg::cache_addr_t addr;
    endpoint_pkg::word_t wdata;
    logic [3:0] strobe;
    endpoint_pkg::word_t rdata;

    // Master side of a cache access.
    modport requester (
        output wen, ren, addr, wdata, strobe,
        input rdata
    );

    // Read data comes back in the same cycle.
    modport cache (
        input wen, ren, addr, wdata, strobe,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/endpoint_pkg.sv ====
`default_nettype none

package endpoint_pkg;

    // ##############################
    // Widths
    // ##############################

    typedef logic [31:0] word_t;
    typedef logic [15:0] host_addr_t;
    typedef logic [6:0] cache_addr_t;
    typedef logic [7:0] node_id_t;
    typedef logic [1:0] msg_idx_t;
    typedef logic [7:0] pkt_len_t;
    typedef logic [15:0] pkt_count_t;

    localparam int NUM_MSGS = 4;
    localparam int CACHE_WORDS = 128;
    localparam int LINK_CREDITS = 4;

    // Holds 0 up to LINK_CREDITS.
    typedef logic [$clog2(LINK_CREDITS + 1)-1:0] credit_t;

    // ##############################
    // Host address map
    // ##############################

    localparam host_addr_t PKT_START_BASE = 16'h0000;
    localparam host_addr_t TX_SEND_ADDR = 16'h1004;
    localparam host_addr_t RX_STATUS_ADDR = 16'h1008;
    localparam host_addr_t TX_CACHE_BASE = 16'h2000;
    localparam host_addr_t RX_CACHE_BASE = 16'h3000;
    localparam word_t BAD_READ_DATA = 32'hBAD1BAD1;

    // Header field offsets.
    localparam int HDR_DST_LSB = 24;
    localparam int HDR_SRC_LSB = 16;
    localparam int HDR_LEN_LSB = 0;

    typedef enum logic [1:0] {
        SND_IDLE,
        SND_HEADER,
        SND_PAYLOAD,
        SND_CHECKSUM
    } sender_state_t;

    typedef enum logic [1:0] {
        RCV_HEADER,
        RCV_PAYLOAD,
        RCV_CHECKSUM
    } receiver_state_t;

endpackage

`default_nettype wire
